/* tb.f */
verilog/nn_pkg.sv
verilog/nn_regs.sv
verilog/nn_sequencer.sv
verilog/nn_mac_alu.sv
verilog/nn_top.sv
verification/nn_sva.sv
verification/tb_nn.sv

/* Makefile */
# Verilator build and run of the neuron engine testbench

VERILATOR ?= verilator
TOP       ?= tb_nn
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/tb_nn.sv */
`timescale 1ns/1ps

module tb_nn;

  localparam int CLK_PERIOD   = 40;
  localparam int ACC_W        = 20;
  localparam int PROG_DEPTH   = 32;  // Deep enough for a MAC chain to reach the clamp
  localparam int ACC_MAX      = (1 << (ACC_W - 1)) - 1;
  localparam int ACC_MIN      = -(1 << (ACC_W - 1));
  localparam int HS_LIMIT     = 20;  // Cycles allowed for one AXI handshake
  localparam int POLL_MAX     = 40;
  localparam int ACCESS_CYC   = 8;   // Worst case for one AXI access
  localparam int NUM_RUNS     = 17;
  localparam int RUN_CYC      = (PROG_DEPTH + 1 + POLL_MAX) * ACCESS_CYC;
  localparam int WATCHDOG_CYC = 2 * (NUM_RUNS * RUN_CYC + 64 * ACCESS_CYC);

  logic        clk;
  logic        rst_n;
  logic [7:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [7:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  logic [17:0] prog [PROG_DEPTH];  // Program image that run_program writes to the DUT
  logic [31:0] lcg_state;
  int          checks;
  int          errors;

  nn_top #(.acc_width(ACC_W), .prog_depth(PROG_DEPTH)) u_dut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lcg();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {16'h0, lcg_state[31:16]};  // Upper half has the better period
  endfunction

  function automatic logic [17:0] make_word(input nn_pkg::opcode_e op, input int coeff,
                                            input int neuron);
    return {op, neuron[7:0], coeff[7:0]};
  endfunction

  function automatic logic [31:0] ctrl_word(input logic start, input logic pause,
                                            input logic en, input logic sign);
    return {28'h0, sign, en, pause, start};
  endfunction

  // Expected accumulator after the words up to HALT or the end of the program
  function automatic int model_acc(input logic sign, input logic en);
    int acc;
    int c;
    int n;
    acc = 0;
    for (int i = 0; i < PROG_DEPTH; i++) begin
      c = prog[i][7:0];
      n = prog[i][15:8];
      if (c > 127) c -= 256;
      if (sign && n > 127) n -= 256;
      if (prog[i][17:16] == nn_pkg::HALT) break;
      if (!en) begin
        acc = 0;
      end else if (prog[i][17:16] == nn_pkg::LOAD) begin
        acc = c;
      end else if (prog[i][17:16] == nn_pkg::MAC) begin
        acc = acc + c * n;
        if (acc > ACC_MAX) acc = ACC_MAX;
        if (acc < ACC_MIN) acc = ACC_MIN;
      end
    end
    return acc;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0d ns: %s expected 0x%08h, actual 0x%08h",
               $time, name, expected, actual);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("Finished %s with %0d errors", name, errors - errors_before);
  endtask

  task automatic fill_nop();
    for (int i = 0; i < PROG_DEPTH; i++) prog[i] = make_word(nn_pkg::NOP, i * 7, 255 - i);
  endtask

  ////////////////////////////////////////
  // AXI4-Lite master
  ////////////////////////////////////////

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
    int n;
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hf;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!awready && n < HS_LIMIT);
    @(negedge clk);  // Address and data are taken on the edge just passed
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    while (!bvalid && n < HS_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!bvalid) begin
      errors++;
      $display("Write to address 0x%02h got no write response", addr);
    end
    check_value("BRESP", 32'(2'b00), 32'(bresp));
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
    int n;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!arready && n < HS_LIMIT);
    @(negedge clk);
    arvalid = 1'b0;
    n = 0;
    while (!rvalid && n < HS_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!rvalid) begin
      errors++;
      $display("Read from address 0x%02h got no read data", addr);
    end
    data = rdata;
    check_value("RRESP", 32'(2'b00), 32'(rresp));
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  // Loads and starts the image, holds it paused for pause_polls reads and waits for done
  task automatic run_program(input logic sign, input logic en, input int pause_polls);
    logic [31:0] status;
    int          polls;
    for (int i = 0; i < PROG_DEPTH; i++) begin
      axi_write(nn_pkg::ADDR_PROG_BASE + 8'(4 * i), 32'(prog[i]));
    end
    axi_write(nn_pkg::ADDR_CTRL, ctrl_word(1'b1, pause_polls > 0, en, sign));
    for (int i = 0; i < pause_polls; i++) begin
      axi_read(nn_pkg::ADDR_STATUS, status);
      check_value("STATUS", 32'h1, status);  // Busy and not yet done
    end
    if (pause_polls > 0) axi_write(nn_pkg::ADDR_CTRL, ctrl_word(1'b0, 1'b0, en, sign));
    polls = 0;
    do begin
      axi_read(nn_pkg::ADDR_STATUS, status);
      polls++;
    end while (!status[1] && polls < POLL_MAX);
    if (!status[1]) begin
      errors++;
      $display("Program did not finish within %0d status polls", POLL_MAX);
    end
    check_value("STATUS", 32'h2, status);
  endtask

  task automatic check_result(input int expected, output logic [31:0] data);
    axi_read(nn_pkg::ADDR_RESULT, data);
    check_value("RESULT", expected, data);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic reset_and_map();
    logic [31:0] data;
    int          errs0;
    errs0 = errors;
    axi_read(nn_pkg::ADDR_STATUS, data);
    check_value("STATUS", 32'h0, data);
    axi_read(nn_pkg::ADDR_RESULT, data);
    check_value("RESULT", 32'h0, data);
    axi_read(nn_pkg::ADDR_CTRL, data);
    check_value("CTRL", 32'h0, data);
    axi_write(nn_pkg::ADDR_PROG_BASE + 8'h0c, 32'hfff3_a5c3);
    axi_read(nn_pkg::ADDR_PROG_BASE + 8'h0c, data);
    check_value("PROG[3]", 32'h0003_a5c3, {14'h0, data[17:0]});
    axi_read(8'h0c, data);
    check_value("unmapped 0x0c", 32'h0, data);
    axi_read(8'hc0, data);  // First offset past the program words
    check_value("unmapped 0xc0", 32'h0, data);
    report_test("reset and map", errs0);
  endtask

  task automatic accumulate();
    logic [31:0] data;
    int          errs0;
    errs0 = errors;
    fill_nop();
    prog[0] = make_word(nn_pkg::LOAD, 10, 0);
    prog[1] = make_word(nn_pkg::MAC, 3, 7);
    prog[2] = make_word(nn_pkg::MAC, -5, 4);
    prog[3] = make_word(nn_pkg::MAC, 100, -2);
    prog[4] = make_word(nn_pkg::MAC, -128, 127);
    prog[5] = make_word(nn_pkg::HALT, 0, 0);
    run_program(1'b1, 1'b1, 0);
    check_result(model_acc(1'b1, 1'b1), data);
    report_test("accumulate", errs0);
  endtask

  task automatic saturation();
    logic [31:0] data;
    int          errs0;
    errs0 = errors;
    for (int i = 0; i < 24; i++) prog[i] = make_word(nn_pkg::MAC, 127, 255);
    for (int i = 24; i < PROG_DEPTH; i++) prog[i] = make_word(nn_pkg::HALT, 0, 0);
    run_program(1'b0, 1'b1, 0);
    check_result(ACC_MAX, data);
    for (int i = 0; i < 24; i++) prog[i] = make_word(nn_pkg::MAC, -128, 255);
    run_program(1'b0, 1'b1, 0);
    check_result(ACC_MIN, data);
    report_test("saturation", errs0);
  endtask

  task automatic sign_and_enable();
    logic [31:0] res_unsigned;
    logic [31:0] res_signed;
    logic [31:0] data;
    int          errs0;
    errs0 = errors;
    fill_nop();
    prog[0] = make_word(nn_pkg::LOAD, 5, 0);
    prog[1] = make_word(nn_pkg::MAC, 3, 8'h90);
    prog[2] = make_word(nn_pkg::MAC, -2, 8'hc8);
    prog[3] = make_word(nn_pkg::HALT, 0, 0);
    run_program(1'b0, 1'b1, 0);
    check_result(model_acc(1'b0, 1'b1), res_unsigned);
    run_program(1'b1, 1'b1, 0);
    check_result(model_acc(1'b1, 1'b1), res_signed);
    if (res_signed == res_unsigned) begin
      errors++;
      $display("Neuron sign select made no difference to the result");
    end
    run_program(1'b1, 1'b0, 0);
    check_result(0, data);  // Disabled neuron
    report_test("neuron sign and enable", errs0);
  endtask

  task automatic pause_run();
    logic [31:0] data;
    int          errs0;
    errs0 = errors;
    fill_nop();
    prog[0] = make_word(nn_pkg::LOAD, 20, 0);
    prog[1] = make_word(nn_pkg::MAC, 9, 8'hf0);
    prog[2] = make_word(nn_pkg::MAC, -7, 8'h33);
    prog[3] = make_word(nn_pkg::HALT, 0, 0);
    run_program(1'b1, 1'b1, 8);
    check_result(model_acc(1'b1, 1'b1), data);
    report_test("pause", errs0);
  endtask

  task automatic random_programs();
    nn_pkg::opcode_e op;
    logic [31:0]     r;
    logic [31:0]     data;
    logic            sign;
    int              errs0;
    errs0 = errors;
    for (int p = 0; p < 10; p++) begin
      r    = lcg();
      sign = r[0];
      for (int i = 0; i < PROG_DEPTH; i++) begin
        r  = lcg();
        op = nn_pkg::opcode_e'(r[1:0]);
        // HALT is kept rare, and the last program runs to its final word
        if (op == nn_pkg::HALT && (p == 9 || r[4:2] != 3'd0)) op = nn_pkg::MAC;
        prog[i] = make_word(op, int'(lcg()), int'(lcg()));
      end
      run_program(sign, 1'b1, 0);
      check_result(model_acc(sign, 1'b1), data);
    end
    report_test("random programs", errs0);
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    lcg_state = 32'd782;
    checks    = 0;
    errors    = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    reset_and_map();
    accumulate();
    saturation();
    sign_and_enable();
    pause_run();
    random_programs();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYC);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* verification/nn_sva.sv */
`timescale 1ns/1ps

module nn_sva #(
  parameter int prog_depth = 16
) (
  input logic                          clk,
  input logic                          rst_n,
  input logic                          awready,
  input logic                          wready,
  input logic                          bvalid,
  input logic                          bready,
  input logic                          rvalid,
  input logic                          rready,
  input logic                          pause,
  input logic                          busy,
  input logic                          start_pulse,
  input logic [$clog2(prog_depth)-1:0] pc
);

  ////////////////////////////////////////
  // AXI4-Lite handshake
  ////////////////////////////////////////

  assert property (@(posedge clk) disable iff (!rst_n) bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");  // Response held until taken
  assert property (@(posedge clk) disable iff (!rst_n) rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");
  assert property (@(posedge clk) disable iff (!rst_n) awready == wready)
    else $error("awready and wready differ");

  ////////////////////////////////////////
  // Run state
  ////////////////////////////////////////

  // A start on the same edge may still reset pc
  assert property (@(posedge clk) disable iff (!rst_n) pause && !start_pulse |=> $stable(pc))
    else $error("pc moved while paused");
  assert property (@(posedge clk) disable iff (!rst_n) $rose(busy) |-> $past(start_pulse))
    else $error("busy rose without a start pulse");

endmodule

bind nn_top nn_sva #(.prog_depth(prog_depth)) u_sva (.*);

/* verilog/nn_top.sv */
`timescale 1ns/1ps

module nn_top #(
  parameter int acc_width  = 20,
  parameter int prog_depth = 16
) (
  input  logic        clk,
  input  logic        rst_n,
  // AXI4-Lite slave
  input  logic [7:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [7:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready
);

  ////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////

  logic                          start_pulse;
  logic                          pause;
  logic                          neuron_en;
  logic                          neuron_sign;  // Goes straight to the ALU
  logic [$clog2(prog_depth)-1:0] pc;
  nn_pkg::opcode_e               prog_opcode;
  logic [nn_pkg::DATA_W-1:0]     prog_coeff;
  logic [nn_pkg::DATA_W-1:0]     prog_neuron;
  logic                          busy;
  logic                          done_pulse;
  logic signed [acc_width-1:0]   result;
  logic signed [acc_width-1:0]   acc;
  logic                          alu_hold;
  logic                          alu_neuron_en;
  nn_pkg::opcode_e               alu_opcode;
  logic [nn_pkg::DATA_W-1:0]     alu_coeff;
  logic [nn_pkg::DATA_W-1:0]     alu_neuron;

  nn_regs #(.acc_width(acc_width), .prog_depth(prog_depth)) u_regs (
    .clk, .rst_n,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .start_pulse, .pause, .neuron_en, .neuron_sign,
    .pc, .prog_opcode, .prog_coeff, .prog_neuron,
    .busy, .done_pulse, .result
  );

  nn_sequencer #(.acc_width(acc_width), .prog_depth(prog_depth)) u_seq (
    .clk, .rst_n, .start_pulse, .pause, .neuron_en,
    .prog_opcode, .prog_coeff, .prog_neuron, .acc,
    .pc, .busy, .done_pulse, .result,
    .alu_hold, .alu_neuron_en, .alu_opcode, .alu_coeff, .alu_neuron
  );

  nn_mac_alu #(.acc_width(acc_width)) u_alu (
    .clk, .rst_n,
    .hold(alu_hold), .neuron_en(alu_neuron_en), .neuron_sign,
    .opcode(alu_opcode), .coeff(alu_coeff), .neuron(alu_neuron), .acc
  );

endmodule

/* verilog/nn_mac_alu.sv */
`timescale 1ns/1ps

module nn_mac_alu #(
  parameter int acc_width = 20
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        hold,
  input  logic                        neuron_en,
  input  logic                        neuron_sign,
  input  nn_pkg::opcode_e             opcode,
  input  logic [nn_pkg::DATA_W-1:0]   coeff,
  input  logic [nn_pkg::DATA_W-1:0]   neuron,
  output logic signed [acc_width-1:0] acc
);

  localparam int op_w = nn_pkg::DATA_W + 1;  // One spare bit for an unsigned neuron
  localparam logic signed [acc_width-1:0] acc_max = {1'b0, {(acc_width-1){1'b1}}};
  localparam logic signed [acc_width-1:0] acc_min = {1'b1, {(acc_width-1){1'b0}}};

  logic signed [op_w-1:0]      opa;
  logic signed [op_w-1:0]      opb;
  logic signed [2*op_w-1:0]    product;
  logic signed [acc_width:0]   sum_raw;  // One guard bit above the accumulator
  logic signed [acc_width-1:0] sum_sat;

  always_comb begin
    opa = {coeff[nn_pkg::DATA_W-1], coeff};
    if (neuron_sign) opb = {neuron[nn_pkg::DATA_W-1], neuron};
    else opb = {1'b0, neuron};
    product = opa * opb;
    sum_raw = product + acc;
    // Top two bits disagree only when the sum left the accumulator range
    case (sum_raw[acc_width:acc_width-1])
      2'b01:   sum_sat = acc_max;
      2'b10:   sum_sat = acc_min;
      default: sum_sat = sum_raw[acc_width-1:0];
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc <= '0;
    end else if (!hold) begin
      if (!neuron_en) begin
        acc <= '0;  // Disabled neuron always reads zero
      end else begin
        case (opcode)
          nn_pkg::HALT: acc <= '0;
          nn_pkg::LOAD: acc <= opa;  // Sign-extends to the accumulator width
          nn_pkg::MAC:  acc <= sum_sat;
          default:      acc <= acc;
        endcase
      end
    end
  end

endmodule

/* verilog/nn_sequencer.sv */
`timescale 1ns/1ps

module nn_sequencer #(
  parameter int acc_width  = 20,
  parameter int prog_depth = 16
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start_pulse,
  input  logic                          pause,
  input  logic                          neuron_en,
  input  nn_pkg::opcode_e               prog_opcode,
  input  logic [nn_pkg::DATA_W-1:0]     prog_coeff,
  input  logic [nn_pkg::DATA_W-1:0]     prog_neuron,
  input  logic signed [acc_width-1:0]   acc,
  output logic [$clog2(prog_depth)-1:0] pc,
  output logic                          busy,
  output logic                          done_pulse,
  output logic signed [acc_width-1:0]   result,
  output logic                          alu_hold,
  output logic                          alu_neuron_en,
  output nn_pkg::opcode_e               alu_opcode,
  output logic [nn_pkg::DATA_W-1:0]     alu_coeff,
  output logic [nn_pkg::DATA_W-1:0]     alu_neuron
);

  typedef enum logic {
    IDLE,
    RUN
  } run_state_e;

  localparam int pc_w = $clog2(prog_depth);
  localparam logic [pc_w-1:0] pc_last = pc_w'(prog_depth - 1);

  run_state_e state;
  logic       past_end;     // Last word issued, pc now stands beyond the program
  logic       start_cycle;
  logic       step;         // Running and not paused
  logic       issue;        // A real word goes to the ALU this cycle
  logic       finish;

  assign start_cycle = start_pulse && (state == IDLE);
  assign step        = (state == RUN) && !pause;
  assign issue       = step && !past_end;
  assign finish      = step && (past_end || (prog_opcode == nn_pkg::HALT));
  assign busy        = (state == RUN);

  ////////////////////////////////////////
  // Instruction issue
  ////////////////////////////////////////

  // The start cycle runs the ALU once with enable low, which clears acc
  assign alu_hold      = !(start_cycle || issue);
  assign alu_neuron_en = neuron_en && !start_cycle;
  assign alu_opcode    = issue ? prog_opcode : nn_pkg::NOP;
  assign alu_coeff     = prog_coeff;
  assign alu_neuron    = prog_neuron;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= IDLE;
      pc         <= '0;
      past_end   <= 1'b0;
      done_pulse <= 1'b0;
      result     <= '0;
    end else begin
      done_pulse <= finish;
      if (start_cycle) begin
        state    <= RUN;
        pc       <= '0;
        past_end <= 1'b0;
      end else if (finish) begin
        state  <= IDLE;
        result <= acc;  // acc as it stood before the HALT word
      end else if (step) begin
        pc <= pc + 1'b1;  // Wraps after the last word, past_end marks it
        if (pc == pc_last) past_end <= 1'b1;
      end
    end
  end

endmodule

/* verilog/nn_regs.sv */
`timescale 1ns/1ps

module nn_regs #(
  parameter int acc_width  = 20,
  parameter int prog_depth = 16
) (
  input  logic                          clk,
  input  logic                          rst_n,
  // AXI4-Lite slave
  input  logic [7:0]                    awaddr,
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [31:0]                   wdata,
  input  logic [3:0]                    wstrb,
  input  logic                          wvalid,
  output logic                          wready,
  output logic [1:0]                    bresp,
  output logic                          bvalid,
  input  logic                          bready,
  input  logic [7:0]                    araddr,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [31:0]                   rdata,
  output logic [1:0]                    rresp,
  output logic                          rvalid,
  input  logic                          rready,
  // Control and program fetch
  output logic                          start_pulse,
  output logic                          pause,
  output logic                          neuron_en,
  output logic                          neuron_sign,
  input  logic [$clog2(prog_depth)-1:0] pc,
  output nn_pkg::opcode_e               prog_opcode,
  output logic [nn_pkg::DATA_W-1:0]     prog_coeff,
  output logic [nn_pkg::DATA_W-1:0]     prog_neuron,
  input  logic                          busy,
  input  logic                          done_pulse,
  input  logic signed [acc_width-1:0]   result
);

  localparam int pc_w   = $clog2(prog_depth);
  localparam int word_w = 2 * nn_pkg::DATA_W + 2;  // coeff, neuron, opcode
  localparam logic [8:0] prog_end = 9'(nn_pkg::ADDR_PROG_BASE) + 9'(4 * prog_depth);

  logic [word_w-1:0] prog_mem [prog_depth];
  logic [word_w-1:0] cur_word;
  logic [31:0]       wr_mask;
  logic [31:0]       rd_data_nxt;
  logic [7:0]        wr_off;
  logic [7:0]        rd_off;
  logic              wr_prog_hit;
  logic              rd_prog_hit;
  logic              wr_en;
  logic              rd_en;
  logic              done_flag;  // Sticky until the next start

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  assign wr_en   = awready && wready && awvalid && wvalid;
  assign rd_en   = arready && arvalid;
  assign wr_mask = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
  assign wr_off  = awaddr - nn_pkg::ADDR_PROG_BASE;
  assign rd_off  = araddr - nn_pkg::ADDR_PROG_BASE;

  assign wr_prog_hit = (awaddr[1:0] == 2'b00) && (awaddr >= nn_pkg::ADDR_PROG_BASE)
                       && ({1'b0, awaddr} < prog_end);
  assign rd_prog_hit = (araddr[1:0] == 2'b00) && (araddr >= nn_pkg::ADDR_PROG_BASE)
                       && ({1'b0, araddr} < prog_end);

  // A start during a run is dropped here, so done is not disturbed either
  assign start_pulse = wr_en && (awaddr == nn_pkg::ADDR_CTRL) && wstrb[0]
                       && wdata[nn_pkg::CTRL_START] && !busy;

  assign bresp = 2'b00;  // Always OKAY
  assign rresp = 2'b00;

  ////////////////////////////////////////
  // Handshakes and control bits
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      awready     <= 1'b0;
      wready      <= 1'b0;
      bvalid      <= 1'b0;
      arready     <= 1'b0;
      rvalid      <= 1'b0;
      pause       <= 1'b0;
      neuron_en   <= 1'b0;
      neuron_sign <= 1'b0;
      done_flag   <= 1'b0;
    end else begin
      // Both ready lines pulse together, one write in flight at most
      awready <= awvalid && wvalid && !bvalid && !awready;
      wready  <= awvalid && wvalid && !bvalid && !awready;
      arready <= arvalid && !arready && !rvalid;
      if (bvalid && bready) bvalid <= 1'b0;
      if (wr_en) bvalid <= 1'b1;
      if (rvalid && rready) rvalid <= 1'b0;
      if (rd_en) rvalid <= 1'b1;
      if (wr_en && (awaddr == nn_pkg::ADDR_CTRL) && wstrb[0]) begin
        pause       <= wdata[nn_pkg::CTRL_PAUSE];
        neuron_en   <= wdata[nn_pkg::CTRL_NEURON_EN];
        neuron_sign <= wdata[nn_pkg::CTRL_NEURON_SIGN];
      end
      if (start_pulse) done_flag <= 1'b0;
      else if (done_pulse) done_flag <= 1'b1;
    end
  end

  // Read data mux, unmapped offsets give zero
  always_comb begin
    rd_data_nxt = '0;
    if (rd_prog_hit) begin
      rd_data_nxt = 32'(prog_mem[rd_off[pc_w+1:2]]);
    end else begin
      case (araddr)
        nn_pkg::ADDR_CTRL: begin
          rd_data_nxt[nn_pkg::CTRL_PAUSE]       = pause;
          rd_data_nxt[nn_pkg::CTRL_NEURON_EN]   = neuron_en;
          rd_data_nxt[nn_pkg::CTRL_NEURON_SIGN] = neuron_sign;
        end
        nn_pkg::ADDR_STATUS: begin
          rd_data_nxt[nn_pkg::STATUS_BUSY] = busy;
          rd_data_nxt[nn_pkg::STATUS_DONE] = done_flag;
        end
        nn_pkg::ADDR_RESULT: rd_data_nxt = {{(32-acc_width){result[acc_width-1]}}, result};
        default: rd_data_nxt = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && wr_prog_hit) begin  // Byte lanes merge into the stored word
      prog_mem[wr_off[pc_w+1:2]] <= (prog_mem[wr_off[pc_w+1:2]] & ~wr_mask[word_w-1:0])
                                    | (wdata[word_w-1:0] & wr_mask[word_w-1:0]);
    end
    if (rd_en) rdata <= rd_data_nxt;
  end

  // Fetch port for the sequencer
  assign cur_word    = prog_mem[pc];
  assign prog_coeff  = cur_word[nn_pkg::DATA_W-1:0];
  assign prog_neuron = cur_word[2*nn_pkg::DATA_W-1:nn_pkg::DATA_W];
  assign prog_opcode = nn_pkg::opcode_e'(cur_word[word_w-1:word_w-2]);

endmodule

/* verilog/nn_pkg.sv */
package nn_pkg;

  ////////////////////////////////////////
  // Instruction encoding
  ////////////////////////////////////////

  // Opcode field of a program word, bits 17:16
  typedef enum logic [1:0] {
    NOP  = 2'b00,  // Accumulator keeps its value
    LOAD = 2'b01,  // Accumulator takes the sign-extended coefficient
    MAC  = 2'b10,  // Accumulator adds coefficient times neuron, saturating
    HALT = 2'b11   // End of program, accumulator clears
  } opcode_e;

  // Width of both the coefficient and the neuron value
  localparam int DATA_W = 8;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  localparam logic [7:0] ADDR_CTRL      = 8'h00;
  localparam logic [7:0] ADDR_STATUS    = 8'h04;
  localparam logic [7:0] ADDR_RESULT    = 8'h08;
  localparam logic [7:0] ADDR_PROG_BASE = 8'h40;  // PROG[i] sits at base + 4*i

  // Bit positions inside CTRL
  localparam int CTRL_START       = 0;  // Write one to start, reads as zero
  localparam int CTRL_PAUSE       = 1;
  localparam int CTRL_NEURON_EN   = 2;
  localparam int CTRL_NEURON_SIGN = 3;

  // Bit positions inside STATUS
  localparam int STATUS_BUSY = 0;
  localparam int STATUS_DONE = 1;

endpackage
